// File: tb.f
id_pkg.sv
inst_decode.sv
reg_file.sv
operand_select.sv
id_stage.sv
tb_id_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# the run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /^RESULT: PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// File: tb_id_stage.sv
// tb_id_stage: directed testbench for the ID stage against a reference decode model
`timescale 1ns/100ps

module tb_id_stage
    import id_pkg::*;
();

    localparam int CLK_PERIOD  = 10;
    localparam int NUM_TESTS   = 6;
    localparam int WATCHDOG_NS = NUM_TESTS * 40 * CLK_PERIOD * 2;

    logic        clk;
    logic        arst_n;
    logic        inst_valid;
    logic [31:0] pc;
    logic [31:0] inst;
    logic        wb_wen;
    logic [4:0]  wb_waddr;
    logic [31:0] wb_wdata;
    logic        ex_wen;
    logic [4:0]  ex_waddr;
    logic [31:0] ex_wdata;
    logic        mem_wen;
    logic [4:0]  mem_waddr;
    logic [31:0] mem_wdata;

    logic        o_valid;
    logic [31:0] o_pc;
    alu_op_e     o_alu_op;
    alu_sel_e    o_alu_sel;
    logic [31:0] o_op_a;
    logic [31:0] o_op_b;
    logic        o_reg_wen;
    logic [4:0]  o_reg_waddr;

    logic [31:0] ref_regs [32];     // mirrors committed write-backs
    integer      seed = 32'h560fa267;
    int          errors;
    int          test_errors;
    int          tests_failed;
    string       test_name;

    id_stage #(
        .DATA_W     (32),
        .REG_ADDR_W (5)
    ) dut_i (
        .i_clk        (clk),
        .i_arst_n     (arst_n),
        .i_inst_valid (inst_valid),
        .i_pc         (pc),
        .i_inst       (inst),
        .i_wb_wen     (wb_wen),
        .i_wb_waddr   (wb_waddr),
        .i_wb_wdata   (wb_wdata),
        .i_ex_wen     (ex_wen),
        .i_ex_waddr   (ex_waddr),
        .i_ex_wdata   (ex_wdata),
        .i_mem_wen    (mem_wen),
        .i_mem_waddr  (mem_waddr),
        .i_mem_wdata  (mem_wdata),
        .o_valid      (o_valid),
        .o_pc         (o_pc),
        .o_alu_op     (o_alu_op),
        .o_alu_sel    (o_alu_sel),
        .o_op_a       (o_op_a),
        .o_op_b       (o_op_b),
        .o_reg_wen    (o_reg_wen),
        .o_reg_waddr  (o_reg_waddr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh);
        enc_r = {6'b000000, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        enc_i = {op, rs, rt, imm};
    endfunction

    function automatic logic [4:0] rand_reg();
        rand_reg = 5'($random(seed));
    endfunction

    function automatic alu_sel_e op_class(input alu_op_e op);
        case (op)
            ALU_NOP:                           op_class = SEL_NOP;
            ALU_OR, ALU_AND, ALU_XOR, ALU_NOR: op_class = SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:         op_class = SEL_SHIFT;
            default:                           op_class = SEL_ARITH;
        endcase
    endfunction

    // expected controls for one instruction
    task automatic model(input logic [31:0] ins, output alu_op_e op, output alu_sel_e sel,
                         output logic rs_ren, output logic rt_ren, output logic wen,
                         output logic [4:0] waddr, output logic [31:0] imm);
        logic [15:0] imm16;
        imm16  = ins[IMM_W-1:0];
        rs_ren = 1'b0;
        rt_ren = 1'b0;
        imm    = 32'h0;
        if (ins[31:26] == OP_SPECIAL) begin
            case (ins[5:0])
                FN_OR:   op = ALU_OR;
                FN_AND:  op = ALU_AND;
                FN_XOR:  op = ALU_XOR;
                FN_NOR:  op = ALU_NOR;
                FN_SLL, FN_SLLV: op = ALU_SLL;
                FN_SRL, FN_SRLV: op = ALU_SRL;
                FN_SRA, FN_SRAV: op = ALU_SRA;
                FN_ADD:  op = ALU_ADD;
                FN_ADDU: op = ALU_ADDU;
                FN_SUB:  op = ALU_SUB;
                FN_SUBU: op = ALU_SUBU;
                FN_SLT:  op = ALU_SLT;
                FN_SLTU: op = ALU_SLTU;
                default: op = ALU_NOP;
            endcase
            if (ins[5:0] inside {FN_SLL, FN_SRL, FN_SRA}) begin
                if (ins[31:21] != 11'd0) begin
                    op = ALU_NOP;   // malformed constant shift
                end else begin
                    rt_ren = 1'b1;
                    imm    = 32'(ins[SHAMT_LSB +: FIELD_W]);
                end
            end else begin
                rs_ren = (op != ALU_NOP);
                rt_ren = (op != ALU_NOP);
            end
            wen   = (op != ALU_NOP);
            waddr = wen ? ins[RD_LSB +: FIELD_W] : 5'd0;
        end else begin
            case (ins[31:26])
                OP_ORI, OP_LUI: op = ALU_OR;
                OP_ANDI:  op = ALU_AND;
                OP_XORI:  op = ALU_XOR;
                OP_SLTI:  op = ALU_SLT;
                OP_SLTIU: op = ALU_SLTU;
                OP_ADDI:  op = ALU_ADDI;
                OP_ADDIU: op = ALU_ADDIU;
                default:  op = ALU_NOP;
            endcase
            case (ins[31:26])
                OP_ORI, OP_ANDI, OP_XORI: imm = {16'h0, imm16};
                OP_LUI: imm = {imm16, 16'h0};
                OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU: imm = {{16{imm16[15]}}, imm16};
                default: imm = 32'h0;
            endcase
            rs_ren = (op != ALU_NOP);
            wen    = rs_ren;
            waddr  = wen ? ins[RT_LSB +: FIELD_W] : 5'd0;
        end
        sel = op_class(op);
    endtask

    // ex first, then mem, then register file with write-through
    function automatic logic [31:0] expect_operand(input logic ren, input logic [4:0] addr,
                                                   input logic [31:0] imm);
        if (!ren)
            return imm;
        if (ex_wen && ex_waddr == addr)
            return ex_wdata;
        if (mem_wen && mem_waddr == addr)
            return mem_wdata;
        if (wb_wen && wb_waddr == addr && addr != 5'd0)
            return wb_wdata;
        return ref_regs[addr];
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else begin
            $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (wb_wen && wb_waddr != 5'd0) begin
            ref_regs[wb_waddr] = wb_wdata;
        end
        inst_valid = 1'b0;
        wb_wen     = 1'b0;
        ex_wen     = 1'b0;
        mem_wen    = 1'b0;
    endtask

    task automatic write_back(input logic [4:0] addr, input logic [31:0] data);
        wb_wen   = 1'b1;
        wb_waddr = addr;
        wb_wdata = data;
        next_cycle();
    endtask

    // one instruction in, all outputs checked one cycle later
    task automatic issue(input logic [31:0] ins);
        alu_op_e     op;
        alu_sel_e    sel;
        logic        rs_ren;
        logic        rt_ren;
        logic        wen;
        logic [4:0]  waddr;
        logic [31:0] imm;
        logic [31:0] exp_a;
        logic [31:0] exp_b;
        model(ins, op, sel, rs_ren, rt_ren, wen, waddr, imm);
        exp_a      = expect_operand(rs_ren, ins[RS_LSB +: FIELD_W], imm);
        exp_b      = expect_operand(rt_ren, ins[RT_LSB +: FIELD_W], imm);
        pc         = pc + 32'd4;
        inst       = ins;
        inst_valid = 1'b1;
        next_cycle();
        check("valid", 32'd1, 32'(o_valid));
        check("pc", pc, o_pc);
        check("alu_op", 32'(op), 32'(o_alu_op));
        check("alu_sel", 32'(sel), 32'(o_alu_sel));
        check("op_a", exp_a, o_op_a);
        check("op_b", exp_b, o_op_b);
        check("reg_wen", 32'(wen), 32'(o_reg_wen));
        check("reg_waddr", 32'(waddr), 32'(o_reg_waddr));
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            $display("%s: passed", test_name);
        end else begin
            $display("%s: failed, %0d errors", test_name, errors - test_errors);
            tests_failed++;
        end
    endtask

    task automatic test_reset();
        begin_test("reset");
        repeat (5) begin
            next_cycle();
            check("valid", 32'd0, 32'(o_valid));
            check("reg_wen", 32'd0, 32'(o_reg_wen));
        end
        // all registered outputs cleared while reset is held
        check("pc", 32'd0, o_pc);
        check("alu_op", 32'd0, 32'(o_alu_op));
        check("alu_sel", 32'd0, 32'(o_alu_sel));
        check("op_a", 32'd0, o_op_a);
        check("op_b", 32'd0, o_op_b);
        check("reg_waddr", 32'd0, 32'(o_reg_waddr));
        arst_n = 1'b1;
        next_cycle();
        check("valid", 32'd0, 32'(o_valid));
        check("reg_wen", 32'd0, 32'(o_reg_wen));
        end_test();
    endtask

    task automatic test_rtype();
        logic [5:0] fns [12];
        fns = '{FN_OR, FN_AND, FN_XOR, FN_NOR, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
                FN_SLT, FN_SLTU, FN_SRLV, FN_SRAV};
        begin_test("register_ops");
        for (int r = 1; r < 32; r++) begin
            write_back(5'(r), $random(seed));
        end
        foreach (fns[i]) begin
            issue(enc_r(fns[i], rand_reg(), rand_reg(), rand_reg(), 5'd0));
        end
        end_test();
    endtask

    task automatic test_immediate();
        logic [5:0] ops [8];
        ops = '{OP_ORI, OP_ANDI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU};
        begin_test("immediates");
        foreach (ops[i]) begin
            // top bit set, negative for the sign-extended forms
            issue(enc_i(ops[i], rand_reg(), rand_reg(), {1'b1, 15'($random(seed))}));
        end
        end_test();
    endtask

    task automatic test_shift();
        begin_test("shifts");
        issue(enc_r(FN_SLL, 5'd0, rand_reg(), rand_reg(), rand_reg()));
        issue(enc_r(FN_SRL, 5'd0, rand_reg(), rand_reg(), rand_reg()));
        issue(enc_r(FN_SRA, 5'd0, rand_reg(), rand_reg(), 5'd31));
        issue(enc_r(FN_SLLV, rand_reg(), rand_reg(), rand_reg(), 5'd0));
        end_test();
    endtask

    task automatic test_forward();
        begin_test("forwarding");
        ex_wen    = 1'b1;           // ex and mem both hit rs
        ex_waddr  = 5'd5;
        ex_wdata  = $random(seed);
        mem_wen   = 1'b1;
        mem_waddr = 5'd5;
        mem_wdata = $random(seed);
        issue(enc_r(FN_ADD, 5'd5, 5'd6, 5'd3, 5'd0));
        mem_wen   = 1'b1;
        mem_waddr = 5'd8;
        mem_wdata = $random(seed);
        issue(enc_r(FN_SUB, 5'd7, 5'd8, 5'd4, 5'd0));
        wb_wen    = 1'b1;           // write-through on rs
        wb_waddr  = 5'd9;
        wb_wdata  = $random(seed);
        issue(enc_r(FN_OR, 5'd9, 5'd10, 5'd11, 5'd0));
        for (int i = 0; i < 3; i++) begin
            ex_wen   = 1'b1;
            ex_waddr = 5'd12 + 5'(i);
            ex_wdata = $random(seed);
            issue(enc_r(FN_ADDU, 5'd12 + 5'(i), 5'd13 + 5'(i), 5'd14, 5'd0));
        end
        end_test();
    endtask

    task automatic test_undefined();
        begin_test("undefined");
        issue(enc_i(6'b000010, rand_reg(), rand_reg(), 16'h1234));
        issue(enc_r(6'b001000, rand_reg(), rand_reg(), rand_reg(), 5'd0));
        issue(enc_r(FN_SLL, 5'd3, rand_reg(), rand_reg(), 5'd4));   // rs field set
        next_cycle();
        check("idle valid", 32'd0, 32'(o_valid));
        check("idle reg_wen", 32'd0, 32'(o_reg_wen));
        end_test();
    endtask

    initial begin
        arst_n       = 1'b0;
        inst_valid   = 1'b0;
        pc           = 32'h0;
        inst         = 32'h0;
        wb_wen       = 1'b0;
        wb_waddr     = 5'd0;
        wb_wdata     = 32'h0;
        ex_wen       = 1'b0;
        ex_waddr     = 5'd0;
        ex_wdata     = 32'h0;
        mem_wen      = 1'b0;
        mem_waddr    = 5'd0;
        mem_wdata    = 32'h0;
        errors       = 0;
        tests_failed = 0;
        foreach (ref_regs[i]) begin
            ref_regs[i] = 32'h0;
        end
        test_reset();
        test_rtype();
        test_immediate();
        test_shift();
        test_forward();
        test_undefined();
        $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: id_stage.sv
// id_stage: instruction decode stage, decoder and register file feeding the ID/EX register
`timescale 1ns/100ps

module id_stage
    import id_pkg::*;
#(
    parameter int DATA_W     = 32,
    parameter int REG_ADDR_W = 5
) (
    input  logic                  i_clk,
    input  logic                  i_arst_n,

    // from fetch
    input  logic                  i_inst_valid,
    input  logic [INST_W-1:0]     i_pc,
    input  logic [INST_W-1:0]     i_inst,

    // write-back port
    input  logic                  i_wb_wen,
    input  logic [REG_ADDR_W-1:0] i_wb_waddr,
    input  logic [DATA_W-1:0]     i_wb_wdata,

    // forwards from execute and memory
    input  logic                  i_ex_wen,
    input  logic [REG_ADDR_W-1:0] i_ex_waddr,
    input  logic [DATA_W-1:0]     i_ex_wdata,
    input  logic                  i_mem_wen,
    input  logic [REG_ADDR_W-1:0] i_mem_waddr,
    input  logic [DATA_W-1:0]     i_mem_wdata,

    // to execute
    output logic                  o_valid,
    output logic [INST_W-1:0]     o_pc,
    output alu_op_e               o_alu_op,
    output alu_sel_e              o_alu_sel,
    output logic [DATA_W-1:0]     o_op_a,
    output logic [DATA_W-1:0]     o_op_b,
    output logic                  o_reg_wen,
    output logic [REG_ADDR_W-1:0] o_reg_waddr
);

    alu_op_e               alu_op;
    alu_sel_e              alu_sel;
    logic                  rs_ren;
    logic                  rt_ren;
    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    logic                  wen;
    logic [REG_ADDR_W-1:0] waddr;
    logic [INST_W-1:0]     imm;
    logic [DATA_W-1:0]     rs_data;
    logic [DATA_W-1:0]     rt_data;

    inst_decode #(
        .REG_ADDR_W (REG_ADDR_W)
    ) decode_i (
        .i_inst    (i_inst),
        .o_alu_op  (alu_op),
        .o_alu_sel (alu_sel),
        .o_rs_ren  (rs_ren),
        .o_rt_ren  (rt_ren),
        .o_rs_addr (rs_addr),
        .o_rt_addr (rt_addr),
        .o_wen     (wen),
        .o_waddr   (waddr),
        .o_imm     (imm)
    );

    reg_file #(
        .DATA_W     (DATA_W),
        .REG_ADDR_W (REG_ADDR_W)
    ) rf_i (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_wen     (i_wb_wen),
        .i_waddr   (i_wb_waddr),
        .i_wdata   (i_wb_wdata),
        .i_raddr_0 (rs_addr),
        .i_raddr_1 (rt_addr),
        .i_ren_0   (rs_ren),
        .i_ren_1   (rt_ren),
        .o_rdata_0 (rs_data),
        .o_rdata_1 (rt_data)
    );

    operand_select #(
        .DATA_W     (DATA_W),
        .REG_ADDR_W (REG_ADDR_W)
    ) opsel_i (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_valid     (i_inst_valid),
        .i_pc        (i_pc),
        .i_alu_op    (alu_op),
        .i_alu_sel   (alu_sel),
        .i_rs_ren    (rs_ren),
        .i_rt_ren    (rt_ren),
        .i_rs_addr   (rs_addr),
        .i_rt_addr   (rt_addr),
        .i_imm       (imm),
        .i_wen       (wen),
        .i_waddr     (waddr),
        .i_rs_data   (rs_data),
        .i_rt_data   (rt_data),
        .i_ex_wen    (i_ex_wen),
        .i_ex_waddr  (i_ex_waddr),
        .i_ex_wdata  (i_ex_wdata),
        .i_mem_wen   (i_mem_wen),
        .i_mem_waddr (i_mem_waddr),
        .i_mem_wdata (i_mem_wdata),
        .o_valid     (o_valid),
        .o_pc        (o_pc),
        .o_alu_op    (o_alu_op),
        .o_alu_sel   (o_alu_sel),
        .o_op_a      (o_op_a),
        .o_op_b      (o_op_b),
        .o_reg_wen   (o_reg_wen),
        .o_reg_waddr (o_reg_waddr)
    );

endmodule

// File: operand_select.sv
// operand_select: forwarding muxes for both source operands and the ID/EX register
`timescale 1ns/100ps

module operand_select
    import id_pkg::*;
#(
    parameter int DATA_W     = 32,
    parameter int REG_ADDR_W = 5
) (
    input  logic                  i_clk,
    input  logic                  i_arst_n,

    input  logic                  i_valid,
    input  logic [INST_W-1:0]     i_pc,
    input  alu_op_e               i_alu_op,
    input  alu_sel_e              i_alu_sel,
    input  logic                  i_rs_ren,
    input  logic                  i_rt_ren,
    input  logic [REG_ADDR_W-1:0] i_rs_addr,
    input  logic [REG_ADDR_W-1:0] i_rt_addr,
    input  logic [INST_W-1:0]     i_imm,
    input  logic                  i_wen,
    input  logic [REG_ADDR_W-1:0] i_waddr,
    input  logic [DATA_W-1:0]     i_rs_data,
    input  logic [DATA_W-1:0]     i_rt_data,

    input  logic                  i_ex_wen,
    input  logic [REG_ADDR_W-1:0] i_ex_waddr,
    input  logic [DATA_W-1:0]     i_ex_wdata,
    input  logic                  i_mem_wen,
    input  logic [REG_ADDR_W-1:0] i_mem_waddr,
    input  logic [DATA_W-1:0]     i_mem_wdata,

    output logic                  o_valid,
    output logic [INST_W-1:0]     o_pc,
    output alu_op_e               o_alu_op,
    output alu_sel_e              o_alu_sel,
    output logic [DATA_W-1:0]     o_op_a,
    output logic [DATA_W-1:0]     o_op_b,
    output logic                  o_reg_wen,
    output logic [REG_ADDR_W-1:0] o_reg_waddr
);

    logic [DATA_W-1:0] imm;
    logic [DATA_W-1:0] op_a_nxt;
    logic [DATA_W-1:0] op_b_nxt;

    // ex beats mem beats register file, disabled port takes the immediate
    function automatic logic [DATA_W-1:0] pick_operand(
        input logic                  ren,
        input logic [REG_ADDR_W-1:0] addr,
        input logic [DATA_W-1:0]     rf_data,
        input logic [DATA_W-1:0]     imm_data,
        input logic                  ex_wen,
        input logic [REG_ADDR_W-1:0] ex_waddr,
        input logic [DATA_W-1:0]     ex_wdata,
        input logic                  mem_wen,
        input logic [REG_ADDR_W-1:0] mem_waddr,
        input logic [DATA_W-1:0]     mem_wdata
    );
        if (!ren) begin
            pick_operand = imm_data;
        end else if (ex_wen && ex_waddr == addr) begin
            pick_operand = ex_wdata;
        end else if (mem_wen && mem_waddr == addr) begin
            pick_operand = mem_wdata;
        end else begin
            pick_operand = rf_data;
        end
    endfunction

    assign imm = DATA_W'(i_imm);

    assign op_a_nxt = pick_operand(i_rs_ren, i_rs_addr, i_rs_data, imm,
                                   i_ex_wen, i_ex_waddr, i_ex_wdata,
                                   i_mem_wen, i_mem_waddr, i_mem_wdata);
    assign op_b_nxt = pick_operand(i_rt_ren, i_rt_addr, i_rt_data, imm,
                                   i_ex_wen, i_ex_waddr, i_ex_wdata,
                                   i_mem_wen, i_mem_waddr, i_mem_wdata);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid     <= 1'b0;
            o_pc        <= '0;
            o_alu_op    <= ALU_NOP;
            o_alu_sel   <= SEL_NOP;
            o_op_a      <= '0;
            o_op_b      <= '0;
            o_reg_wen   <= 1'b0;
            o_reg_waddr <= '0;
        end else begin
            o_valid     <= i_valid;
            o_pc        <= i_pc;
            o_alu_op    <= i_alu_op;
            o_alu_sel   <= i_alu_sel;
            o_op_a      <= op_a_nxt;
            o_op_b      <= op_b_nxt;
            o_reg_wen   <= i_valid & i_wen;  // bubbles never write
            o_reg_waddr <= i_waddr;
        end
    end

    // a write always carries a real operation class to execute
    a_wen_class: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_reg_wen |-> (o_alu_sel != SEL_NOP))
        else $error("operand_select: write enable with NOP class");

endmodule

// File: reg_file.sv
// reg_file: 32-entry register file, two combinational read ports with write-through
`timescale 1ns/100ps

module reg_file #(
    parameter int DATA_W     = 32,
    parameter int REG_ADDR_W = 5
) (
    input  logic                  i_clk,
    input  logic                  i_arst_n,

    input  logic                  i_wen,
    input  logic [REG_ADDR_W-1:0] i_waddr,
    input  logic [DATA_W-1:0]     i_wdata,

    input  logic [REG_ADDR_W-1:0] i_raddr_0,
    input  logic [REG_ADDR_W-1:0] i_raddr_1,
    input  logic                  i_ren_0,
    input  logic                  i_ren_1,
    output logic [DATA_W-1:0]     o_rdata_0,
    output logic [DATA_W-1:0]     o_rdata_1
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [DATA_W-1:0]          regs [NUM_REGS];
    logic                       wr_ok;  // r0 never written
    logic [1:0][REG_ADDR_W-1:0] raddr;
    logic [1:0]                 ren;
    logic [1:0][DATA_W-1:0]     rdata;

    assign wr_ok = i_wen && (i_waddr != '0);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    assign raddr = {i_raddr_1, i_raddr_0};
    assign ren   = {i_ren_1, i_ren_0};

    for (genvar p = 0; p < 2; p++) begin : g_rd
        assign rdata[p] = !ren[p]                       ? '0 :
                          (wr_ok && i_waddr == raddr[p]) ? i_wdata :    // write-through
                                                           regs[raddr[p]];

        // r0 reads zero on every port, even during a write to it
        a_r0_zero: assert property (@(posedge i_clk) disable iff (!i_arst_n)
            (ren[p] && raddr[p] == '0) |-> (rdata[p] == '0))
            else $error("reg_file: r0 read back nonzero on port %0d", p);
    end

    assign o_rdata_0 = rdata[0];
    assign o_rdata_1 = rdata[1];

endmodule

// File: inst_decode.sv
// inst_decode: combinational decode of one instruction into ALU controls, reads and immediate
`timescale 1ns/100ps

module inst_decode
    import id_pkg::*;
#(
    parameter int REG_ADDR_W = 5
) (
    input  logic [INST_W-1:0]     i_inst,

    output alu_op_e               o_alu_op,
    output alu_sel_e              o_alu_sel,
    output logic                  o_rs_ren,
    output logic                  o_rt_ren,
    output logic [REG_ADDR_W-1:0] o_rs_addr,
    output logic [REG_ADDR_W-1:0] o_rt_addr,
    output logic                  o_wen,
    output logic [REG_ADDR_W-1:0] o_waddr,
    output logic [INST_W-1:0]     o_imm
);

    opcode_e            opcode;
    funct_e             funct;
    logic [IMM_W-1:0]   imm16;
    logic [INST_W-1:0]  zext_imm;
    logic [INST_W-1:0]  sext_imm;
    logic [INST_W-1:0]  lui_imm;
    logic [INST_W-1:0]  shamt_imm;
    logic               rr_type;    // reads rs and rt, writes rd
    logic               sh_type;    // constant shift, reads rt, writes rd
    logic               it_type;    // immediate form, reads rs, writes rt

    function automatic alu_sel_e class_of(input alu_op_e op);
        case (op)
            ALU_OR, ALU_AND, ALU_XOR, ALU_NOR: class_of = SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:         class_of = SEL_SHIFT;
            ALU_NOP:                           class_of = SEL_NOP;
            default:                           class_of = SEL_ARITH;
        endcase
    endfunction

    assign opcode = opcode_e'(i_inst[INST_W-1 -: $bits(opcode_e)]);
    assign funct  = funct_e'(i_inst[$bits(funct_e)-1:0]);
    assign imm16  = i_inst[IMM_W-1:0];

    assign zext_imm  = {{(INST_W-IMM_W){1'b0}}, imm16};
    assign sext_imm  = {{(INST_W-IMM_W){imm16[IMM_W-1]}}, imm16};
    assign lui_imm   = {imm16, {(INST_W-IMM_W){1'b0}}};
    assign shamt_imm = {{(INST_W-FIELD_W){1'b0}}, i_inst[SHAMT_LSB +: FIELD_W]};

    // source fields go out as is, the read enables qualify them
    assign o_rs_addr = REG_ADDR_W'(i_inst[RS_LSB +: FIELD_W]);
    assign o_rt_addr = REG_ADDR_W'(i_inst[RT_LSB +: FIELD_W]);

    always_comb begin
        o_alu_op = ALU_NOP;
        o_imm    = '0;
        rr_type  = 1'b0;
        sh_type  = 1'b0;
        it_type  = 1'b0;

        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_OR:   o_alu_op = ALU_OR;
                    FN_AND:  o_alu_op = ALU_AND;
                    FN_XOR:  o_alu_op = ALU_XOR;
                    FN_NOR:  o_alu_op = ALU_NOR;
                    FN_SLL:  o_alu_op = ALU_SLL;
                    FN_SRL:  o_alu_op = ALU_SRL;
                    FN_SRA:  o_alu_op = ALU_SRA;
                    FN_SLLV: o_alu_op = ALU_SLL;
                    FN_SRLV: o_alu_op = ALU_SRL;
                    FN_SRAV: o_alu_op = ALU_SRA;
                    FN_ADD:  o_alu_op = ALU_ADD;
                    FN_ADDU: o_alu_op = ALU_ADDU;
                    FN_SUB:  o_alu_op = ALU_SUB;
                    FN_SUBU: o_alu_op = ALU_SUBU;
                    FN_SLT:  o_alu_op = ALU_SLT;
                    FN_SLTU: o_alu_op = ALU_SLTU;
                    default: o_alu_op = ALU_NOP;
                endcase
                if (funct inside {FN_SLL, FN_SRL, FN_SRA}) begin
                    // constant shifts need bits 31..21 clear
                    sh_type = (i_inst[INST_W-1:RS_LSB] == '0);
                    if (!sh_type) begin
                        o_alu_op = ALU_NOP;
                    end
                end else begin
                    rr_type = (o_alu_op != ALU_NOP);
                end
            end
            OP_ORI: begin
                o_alu_op = ALU_OR;
                o_imm    = zext_imm;
                it_type  = 1'b1;
            end
            OP_ANDI: begin
                o_alu_op = ALU_AND;
                o_imm    = zext_imm;
                it_type  = 1'b1;
            end
            OP_XORI: begin
                o_alu_op = ALU_XOR;
                o_imm    = zext_imm;
                it_type  = 1'b1;
            end
            OP_LUI: begin
                o_alu_op = ALU_OR;    // rs | upper imm
                o_imm    = lui_imm;
                it_type  = 1'b1;
            end
            OP_SLTI: begin
                o_alu_op = ALU_SLT;
                o_imm    = sext_imm;
                it_type  = 1'b1;
            end
            OP_SLTIU: begin
                o_alu_op = ALU_SLTU;
                o_imm    = sext_imm;
                it_type  = 1'b1;
            end
            OP_ADDI: begin
                o_alu_op = ALU_ADDI;
                o_imm    = sext_imm;
                it_type  = 1'b1;
            end
            OP_ADDIU: begin
                o_alu_op = ALU_ADDIU;
                o_imm    = sext_imm;
                it_type  = 1'b1;
            end
            default: begin
            end
        endcase

        o_alu_sel = class_of(o_alu_op);
        o_rs_ren  = rr_type | it_type;
        o_rt_ren  = rr_type | sh_type;
        o_wen     = rr_type | sh_type | it_type;

        if (it_type) begin
            o_waddr = REG_ADDR_W'(i_inst[RT_LSB +: FIELD_W]);
        end else if (rr_type || sh_type) begin
            o_waddr = REG_ADDR_W'(i_inst[RD_LSB +: FIELD_W]);
        end else begin
            o_waddr = '0;
        end

        if (sh_type) begin
            o_imm = shamt_imm;  // shift amount lands on operand a
        end
    end

endmodule

// File: id_pkg.sv
// id_pkg: instruction field positions and decode encodings shared across the ID stage
package id_pkg;

    localparam int INST_W    = 32;  // instruction and pc width
    localparam int FIELD_W   = 5;   // register and shift amount fields
    localparam int IMM_W     = 16;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_LSB = 6;

    // primary opcode, bits 31..26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // function field of SPECIAL, bits 5..0
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    // operation subtype seen by execute
    typedef enum logic [7:0] {
        ALU_NOP   = 8'b00000000,
        ALU_SRL   = 8'b00000010,
        ALU_SRA   = 8'b00000011,
        ALU_ADD   = 8'b00100000,
        ALU_ADDU  = 8'b00100001,
        ALU_SUB   = 8'b00100010,
        ALU_SUBU  = 8'b00100011,
        ALU_AND   = 8'b00100100,
        ALU_OR    = 8'b00100101,
        ALU_XOR   = 8'b00100110,
        ALU_NOR   = 8'b00100111,
        ALU_SLT   = 8'b00101010,
        ALU_SLTU  = 8'b00101011,
        ALU_ADDI  = 8'b01010101,
        ALU_ADDIU = 8'b01010110,
        ALU_SLL   = 8'b01111100
    } alu_op_e;

    // result class
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_ARITH = 3'b100
    } alu_sel_e;

endpackage
